//--- list.f
rtl/fw_pkg.sv
rtl/sync_fifo.sv
rtl/flow_classifier.sv
rtl/verdict_merge.sv
rtl/shell_watchdog.sv
rtl/firewall_shell.sv
bench/firewall_shell_assert.sv
bench/firewall_shell_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the firewall shell testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module firewall_shell_tb -o firewall_shell_sim
output=$(./obj_dir/firewall_shell_sim 2>&1 || true)
echo "$output"
if echo "$output" | grep -qx "sim passed"; then
  exit 0
fi
exit 1

//--- bench/firewall_shell_tb.sv
// firewall shell testbench
`timescale 1ns/10ps

module firewall_shell_tb;

  localparam int TIMEOUT = 2000; // cycles per wait

  logic                            mlx2sbu_clk = 1'b0;
  logic                            arst_n;
  logic [23:0]                     sbu2mlx_ieee_vendor_id;
  logic [15:0]                     sbu2mlx_product_id;
  logic [15:0]                     sbu2mlx_product_version;
  logic [31:0]                     sbu2mlx_caps;
  logic [15:0]                     sbu2mlx_caps_len;
  logic [23:0]                     sbu2mlx_caps_addr;
  logic                            sbu2mlx_watchdog;
  logic                            nwp2sbu_vld;
  logic                            nwp2sbu_rdy;
  logic [fw_pkg::TDATA_W-1:0]      nwp2sbu_tdata;
  logic [fw_pkg::TKEEP_W-1:0]      nwp2sbu_tkeep;
  logic                            nwp2sbu_tlast;
  logic                            sbu2cxp_vld;
  logic                            sbu2cxp_rdy;
  logic [fw_pkg::TDATA_W-1:0]      sbu2cxp_tdata;
  logic [fw_pkg::TKEEP_W-1:0]      sbu2cxp_tkeep;
  logic                            sbu2cxp_tlast;
  logic [fw_pkg::TUSER_W-1:0]      sbu2cxp_tuser;
  logic [fw_pkg::TID_W-1:0]        sbu2cxp_tid;
  logic                            cxp2sbu_vld;
  logic                            cxp2sbu_rdy;
  logic [fw_pkg::TDATA_W-1:0]      cxp2sbu_tdata;
  logic [fw_pkg::TKEEP_W-1:0]      cxp2sbu_tkeep;
  logic                            cxp2sbu_tlast;
  logic [fw_pkg::TUSER_W-1:0]      cxp2sbu_tuser;
  logic [fw_pkg::TID_W-1:0]        cxp2sbu_tid;
  logic                            sbu2nwp_vld;
  logic                            sbu2nwp_rdy;
  logic [fw_pkg::TDATA_W-1:0]      sbu2nwp_tdata;
  logic [fw_pkg::TKEEP_W-1:0]      sbu2nwp_tkeep;
  logic                            sbu2nwp_tlast;
  logic [fw_pkg::TUSER_W-1:0]      sbu2nwp_tuser;
  logic [fw_pkg::TID_W-1:0]        sbu2nwp_tid;
  logic                            cfg_wr;
  logic [fw_pkg::RULE_INDEX_W-1:0] cfg_index;
  logic [fw_pkg::IP_W-1:0]         cfg_dst_ip;
  logic                            cfg_enable;

  logic [31:0]                seed = 32'd76984;
  logic                       saw_stall;
  logic                       rule_en_tb [fw_pkg::RULE_COUNT];
  logic [fw_pkg::IP_W-1:0]    rule_ip_tb [fw_pkg::RULE_COUNT];
  logic [fw_pkg::TDATA_W-1:0] stim_data [$];
  logic [fw_pkg::TKEEP_W-1:0] stim_keep [$];
  logic                       stim_last [$];
  logic [fw_pkg::TDATA_W-1:0] exp_data [$]; // scoreboard
  logic [fw_pkg::TKEEP_W-1:0] exp_keep [$];
  logic                       exp_last [$];
  logic [fw_pkg::TUSER_W-1:0] exp_user [$];

  firewall_shell DUT (.*);

  always #50 mlx2sbu_clk = ~mlx2sbu_clk;

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  // pass if any enabled entry holds the address
  function automatic logic expect_pass(input logic [31:0] dst);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < fw_pkg::RULE_COUNT; i++) begin
      if (rule_en_tb[i] && rule_ip_tb[i] == dst) hit = 1'b1;
    end
    return hit;
  endfunction

  task automatic check(input logic [255:0] got, input logic [255:0] exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0d ns: %s got %0h expected %0h", $time, what, got, exp);
      $display("sim failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_wait(input string what);
    $display("timed out waiting for %s", what);
    $display("sim failed");
    $fatal(1, "wait timed out");
  endtask

  task automatic write_rule(input int idx, input logic [31:0] ip, input logic en);
    @(posedge mlx2sbu_clk);
    cfg_wr     <= 1'b1;
    cfg_index  <= idx[1:0];
    cfg_dst_ip <= ip;
    cfg_enable <= en;
    @(posedge mlx2sbu_clk);
    cfg_wr <= 1'b0;
    rule_en_tb[idx] = en;
    rule_ip_tb[idx] = ip;
  endtask

  task automatic add_packet(input int nbeats, input logic [31:0] dst);
    logic [fw_pkg::TDATA_W-1:0] data;
    logic [fw_pkg::TKEEP_W-1:0] keep;
    for (int b = 0; b < nbeats; b++) begin
      for (int w = 0; w < 8; w++) data[w*32 +: 32] = lcg_next();
      if (b == 0) data[fw_pkg::DST_IP_BYTE*8+7 -: 32] = dst; // byte 30 is the msb
      keep = (b == nbeats - 1) ? (lcg_next() | 32'h1) : '1;
      stim_data.push_back(data);
      stim_keep.push_back(keep);
      stim_last.push_back(b == nbeats - 1);
      exp_data.push_back(data);
      exp_keep.push_back(keep);
      exp_last.push_back(b == nbeats - 1);
      exp_user.push_back((b == 0) ? {11'b0, expect_pass(dst)} : 12'b0);
    end
  endtask

  task automatic drive_ingress();
    int                         waited;
    logic [fw_pkg::TDATA_W-1:0] data;
    logic [fw_pkg::TKEEP_W-1:0] keep;
    logic                       last;
    while (stim_data.size() > 0) begin
      data = stim_data.pop_front();
      keep = stim_keep.pop_front();
      last = stim_last.pop_front();
      @(posedge mlx2sbu_clk);
      nwp2sbu_vld   <= 1'b1;
      nwp2sbu_tdata <= data;
      nwp2sbu_tkeep <= keep;
      nwp2sbu_tlast <= last;
      waited = 0;
      @(negedge mlx2sbu_clk);
      while (!nwp2sbu_rdy) begin
        saw_stall = 1'b1;
        waited++;
        if (waited > TIMEOUT) abort_wait("ingress ready");
        @(negedge mlx2sbu_clk);
      end
    end
    @(posedge mlx2sbu_clk);
    nwp2sbu_vld <= 1'b0;
  endtask

  task automatic collect_egress(input logic bp);
    int          idle;
    logic [31:0] r;
    idle = 0;
    while (exp_data.size() > 0) begin
      r = lcg_next();
      @(posedge mlx2sbu_clk);
      sbu2cxp_rdy <= bp ? (r[20] & r[21]) : 1'b1; // about one cycle in four
      @(negedge mlx2sbu_clk);
      if (sbu2cxp_vld && sbu2cxp_rdy) begin
        check(sbu2cxp_tdata, exp_data.pop_front(), "egress tdata");
        check(sbu2cxp_tkeep, exp_keep.pop_front(), "egress tkeep");
        check(sbu2cxp_tlast, exp_last.pop_front(), "egress tlast");
        check(sbu2cxp_tuser, exp_user.pop_front(), "egress tuser");
        check(sbu2cxp_tid, 3'b0, "egress tid");
        idle = 0;
      end else begin
        idle++;
        if (idle > TIMEOUT) abort_wait("egress beat");
      end
    end
    @(posedge mlx2sbu_clk);
    sbu2cxp_rdy <= 1'b1;
  endtask

  task automatic run_traffic(input logic bp);
    fork
      drive_ingress();
      collect_egress(bp);
    join
  endtask

  task automatic reset_state();
    @(negedge mlx2sbu_clk);
    check(sbu2mlx_ieee_vendor_id, 24'h0002c9, "vendor id");
    check(sbu2mlx_product_id, 16'd4, "product id");
    check(sbu2mlx_product_version, 16'd1, "product version");
    check(sbu2mlx_caps, 32'd2, "caps");
    check(sbu2mlx_caps_len, 16'd0, "caps len");
    check(sbu2mlx_caps_addr, 24'd0, "caps addr");
    check(sbu2cxp_vld, 1'b0, "egress valid after reset");
    check(nwp2sbu_rdy, 1'b1, "ingress ready after reset");
    check(sbu2mlx_watchdog, 1'b0, "watchdog after reset");
  endtask

  // k counts edges since release
  task automatic watchdog_toggle();
    for (int k = 1; k <= 48; k++) begin
      @(negedge mlx2sbu_clk);
      check(sbu2mlx_watchdog, (k / 16) % 2, "watchdog");
    end
  endtask

  task automatic basic_traffic();
    write_rule(0, 32'hc0a80001, 1'b1);
    write_rule(2, 32'h0a000005, 1'b1);
    add_packet(1, 32'hc0a80001);
    add_packet(3, 32'h0a000005);
    add_packet(1, 32'h0a000006);
    add_packet(4, 32'hc0a80002);
    add_packet(2, 32'hc0a80001);
    run_traffic(1'b0);
  endtask

  task automatic backpressure_traffic();
    logic [31:0] r;
    saw_stall = 1'b0;
    for (int p = 0; p < 40; p++) begin
      r = lcg_next();
      add_packet(int'(r[18:16]) + 1, r[23] ? 32'hc0a80001 : {8'h0a, r[31:8]});
    end
    run_traffic(1'b1);
    check(saw_stall, 1'b1, "ingress back-pressure seen");
  endtask

  task automatic rule_rewrite();
    write_rule(0, 32'hc0a80001, 1'b0);
    add_packet(2, 32'hc0a80001);
    run_traffic(1'b0);
    write_rule(0, 32'hac100001, 1'b1);
    add_packet(1, 32'hac100001);
    add_packet(3, 32'hc0a80001);
    add_packet(2, 32'h0a000005);
    run_traffic(1'b0);
  endtask

  task automatic passthrough();
    logic [31:0]                r;
    logic [fw_pkg::TDATA_W-1:0] data;
    for (int n = 0; n < 8; n++) begin
      r = lcg_next();
      for (int w = 0; w < 8; w++) data[w*32 +: 32] = lcg_next();
      @(posedge mlx2sbu_clk);
      cxp2sbu_vld   <= r[0];
      cxp2sbu_tdata <= data;
      cxp2sbu_tkeep <= r;
      cxp2sbu_tlast <= r[1];
      cxp2sbu_tuser <= r[13:2];
      cxp2sbu_tid   <= r[18:16];
      sbu2nwp_rdy   <= r[20];
      @(negedge mlx2sbu_clk);
      check(sbu2nwp_vld, r[0], "passthrough vld");
      check(sbu2nwp_tdata, data, "passthrough tdata");
      check(sbu2nwp_tkeep, r, "passthrough tkeep");
      check(sbu2nwp_tlast, r[1], "passthrough tlast");
      check(sbu2nwp_tuser, r[13:2], "passthrough tuser");
      check(sbu2nwp_tid, r[18:16], "passthrough tid");
      check(cxp2sbu_rdy, r[20], "passthrough rdy");
    end
  endtask

  initial begin
    arst_n        = 1'b0;
    nwp2sbu_vld   = 1'b0;
    nwp2sbu_tdata = '0;
    nwp2sbu_tkeep = '0;
    nwp2sbu_tlast = 1'b0;
    sbu2cxp_rdy   = 1'b1;
    cxp2sbu_vld   = 1'b0;
    cxp2sbu_tdata = '0;
    cxp2sbu_tkeep = '0;
    cxp2sbu_tlast = 1'b0;
    cxp2sbu_tuser = '0;
    cxp2sbu_tid   = '0;
    sbu2nwp_rdy   = 1'b0;
    cfg_wr        = 1'b0;
    cfg_index     = '0;
    cfg_dst_ip    = '0;
    cfg_enable    = 1'b0;
    for (int i = 0; i < fw_pkg::RULE_COUNT; i++) begin
      rule_en_tb[i] = 1'b0;
      rule_ip_tb[i] = '0;
    end
    repeat (2) @(posedge mlx2sbu_clk);
    arst_n <= 1'b1;
    reset_state();
    watchdog_toggle();
    basic_traffic();
    backpressure_traffic();
    rule_rewrite();
    passthrough();
    $display("sim passed");
    $finish;
  end

endmodule

//--- bench/firewall_shell_assert.sv
// egress stream assertions
`timescale 1ns/10ps

module firewall_shell_assert (
  input logic                       mlx2sbu_clk,
  input logic                       arst_n,
  input logic                       sbu2cxp_vld,
  input logic                       sbu2cxp_rdy,
  input logic [fw_pkg::TDATA_W-1:0] sbu2cxp_tdata,
  input logic [fw_pkg::TKEEP_W-1:0] sbu2cxp_tkeep,
  input logic                       sbu2cxp_tlast,
  input logic [fw_pkg::TUSER_W-1:0] sbu2cxp_tuser,
  input logic [fw_pkg::TID_W-1:0]   sbu2cxp_tid
);

  vld_in_reset: assert property (@(posedge mlx2sbu_clk) !arst_n |-> !sbu2cxp_vld)
    else $error("egress valid high during reset");

  // held beat may not change until taken
  vld_hold: assert property (@(posedge mlx2sbu_clk) disable iff (!arst_n)
    sbu2cxp_vld && !sbu2cxp_rdy |=> sbu2cxp_vld && $stable(sbu2cxp_tdata) &&
    $stable(sbu2cxp_tkeep) && $stable(sbu2cxp_tlast) && $stable(sbu2cxp_tuser))
    else $error("egress beat changed before ready");

  tuser_upper: assert property (@(posedge mlx2sbu_clk) disable iff (!arst_n)
    sbu2cxp_tuser[fw_pkg::TUSER_W-1:1] == '0)
    else $error("egress tuser upper bits not zero");

  tid_zero: assert property (@(posedge mlx2sbu_clk) sbu2cxp_tid == '0)
    else $error("egress tid not zero");

endmodule

bind firewall_shell firewall_shell_assert u_assert (
  .mlx2sbu_clk   (mlx2sbu_clk),
  .arst_n        (arst_n),
  .sbu2cxp_vld   (sbu2cxp_vld),
  .sbu2cxp_rdy   (sbu2cxp_rdy),
  .sbu2cxp_tdata (sbu2cxp_tdata),
  .sbu2cxp_tkeep (sbu2cxp_tkeep),
  .sbu2cxp_tlast (sbu2cxp_tlast),
  .sbu2cxp_tuser (sbu2cxp_tuser),
  .sbu2cxp_tid   (sbu2cxp_tid)
);

//--- rtl/firewall_shell.sv
// firewall shell top level
`timescale 1ns/10ps

module firewall_shell (
  input  logic                            mlx2sbu_clk,
  input  logic                            arst_n,
  output logic [23:0]                     sbu2mlx_ieee_vendor_id,
  output logic [15:0]                     sbu2mlx_product_id,
  output logic [15:0]                     sbu2mlx_product_version,
  output logic [31:0]                     sbu2mlx_caps,
  output logic [15:0]                     sbu2mlx_caps_len,
  output logic [23:0]                     sbu2mlx_caps_addr,
  output logic                            sbu2mlx_watchdog,
  input  logic                            nwp2sbu_vld,
  output logic                            nwp2sbu_rdy,
  input  logic [fw_pkg::TDATA_W-1:0]      nwp2sbu_tdata,
  input  logic [fw_pkg::TKEEP_W-1:0]      nwp2sbu_tkeep,
  input  logic                            nwp2sbu_tlast,
  output logic                            sbu2cxp_vld,
  input  logic                            sbu2cxp_rdy,
  output logic [fw_pkg::TDATA_W-1:0]      sbu2cxp_tdata,
  output logic [fw_pkg::TKEEP_W-1:0]      sbu2cxp_tkeep,
  output logic                            sbu2cxp_tlast,
  output logic [fw_pkg::TUSER_W-1:0]      sbu2cxp_tuser,
  output logic [fw_pkg::TID_W-1:0]        sbu2cxp_tid,
  input  logic                            cxp2sbu_vld,
  output logic                            cxp2sbu_rdy,
  input  logic [fw_pkg::TDATA_W-1:0]      cxp2sbu_tdata,
  input  logic [fw_pkg::TKEEP_W-1:0]      cxp2sbu_tkeep,
  input  logic                            cxp2sbu_tlast,
  input  logic [fw_pkg::TUSER_W-1:0]      cxp2sbu_tuser,
  input  logic [fw_pkg::TID_W-1:0]        cxp2sbu_tid,
  output logic                            sbu2nwp_vld,
  input  logic                            sbu2nwp_rdy,
  output logic [fw_pkg::TDATA_W-1:0]      sbu2nwp_tdata,
  output logic [fw_pkg::TKEEP_W-1:0]      sbu2nwp_tkeep,
  output logic                            sbu2nwp_tlast,
  output logic [fw_pkg::TUSER_W-1:0]      sbu2nwp_tuser,
  output logic [fw_pkg::TID_W-1:0]        sbu2nwp_tid,
  input  logic                            cfg_wr,
  input  logic [fw_pkg::RULE_INDEX_W-1:0] cfg_index,
  input  logic [fw_pkg::IP_W-1:0]         cfg_dst_ip,
  input  logic                            cfg_enable
);

  logic beat_accept;
  logic verdict_wr;
  logic verdict;

  logic tuple_full;
  logic tuple_empty;
  logic tuple_rd;
  logic tuple_dout;

  // tdata, tkeep, tlast packed per beat
  logic [fw_pkg::TDATA_W+fw_pkg::TKEEP_W:0] data_din;
  logic [fw_pkg::TDATA_W+fw_pkg::TKEEP_W:0] data_dout;
  logic                                     data_full;
  logic                                     data_empty;
  logic                                     data_rd;

  assign sbu2mlx_ieee_vendor_id  = fw_pkg::VENDOR_ID;
  assign sbu2mlx_product_id      = fw_pkg::PRODUCT_ID;
  assign sbu2mlx_product_version = fw_pkg::PRODUCT_VERSION;
  assign sbu2mlx_caps            = fw_pkg::CAPS;
  assign sbu2mlx_caps_len        = fw_pkg::CAPS_LEN;
  assign sbu2mlx_caps_addr       = fw_pkg::CAPS_ADDR;

  // ingress stalls if either fifo fills
  assign nwp2sbu_rdy = !data_full && !tuple_full;
  assign beat_accept = nwp2sbu_vld && nwp2sbu_rdy;
  assign data_din    = {nwp2sbu_tdata, nwp2sbu_tkeep, nwp2sbu_tlast};

  flow_classifier u_classifier (
    .mlx2sbu_clk (mlx2sbu_clk),
    .arst_n      (arst_n),
    .beat_accept (beat_accept),
    .beat_tdata  (nwp2sbu_tdata),
    .beat_tlast  (nwp2sbu_tlast),
    .cfg_wr      (cfg_wr),
    .cfg_index   (cfg_index),
    .cfg_dst_ip  (cfg_dst_ip),
    .cfg_enable  (cfg_enable),
    .verdict_wr  (verdict_wr),
    .verdict     (verdict)
  );

  sync_fifo #(
    .WIDTH      (1),
    .DEPTH_LOG2 (fw_pkg::FIFO_DEPTH_LOG2)
  ) tuple_fifo (
    .mlx2sbu_clk (mlx2sbu_clk),
    .arst_n      (arst_n),
    .wr_en       (verdict_wr),
    .din         (verdict),
    .rd_en       (tuple_rd),
    .dout        (tuple_dout),
    .full        (tuple_full),
    .empty       (tuple_empty)
  );

  sync_fifo #(
    .WIDTH      (fw_pkg::TDATA_W + fw_pkg::TKEEP_W + 1),
    .DEPTH_LOG2 (fw_pkg::FIFO_DEPTH_LOG2)
  ) data_fifo (
    .mlx2sbu_clk (mlx2sbu_clk),
    .arst_n      (arst_n),
    .wr_en       (beat_accept),
    .din         (data_din),
    .rd_en       (data_rd),
    .dout        (data_dout),
    .full        (data_full),
    .empty       (data_empty)
  );

  verdict_merge u_merge (
    .mlx2sbu_clk   (mlx2sbu_clk),
    .arst_n        (arst_n),
    .data_empty    (data_empty),
    .data_tdata    (data_dout[fw_pkg::TDATA_W+fw_pkg::TKEEP_W -: fw_pkg::TDATA_W]),
    .data_tkeep    (data_dout[fw_pkg::TKEEP_W:1]),
    .data_tlast    (data_dout[0]),
    .tuple_empty   (tuple_empty),
    .tuple_verdict (tuple_dout),
    .egress_rdy    (sbu2cxp_rdy),
    .data_rd       (data_rd),
    .tuple_rd      (tuple_rd),
    .egress_vld    (sbu2cxp_vld),
    .egress_tdata  (sbu2cxp_tdata),
    .egress_tkeep  (sbu2cxp_tkeep),
    .egress_tlast  (sbu2cxp_tlast),
    .egress_tuser  (sbu2cxp_tuser)
  );

  assign sbu2cxp_tid = '0;

  // cxp to nwp passes straight through
  assign sbu2nwp_vld   = cxp2sbu_vld;
  assign cxp2sbu_rdy   = sbu2nwp_rdy;
  assign sbu2nwp_tdata = cxp2sbu_tdata;
  assign sbu2nwp_tkeep = cxp2sbu_tkeep;
  assign sbu2nwp_tlast = cxp2sbu_tlast;
  assign sbu2nwp_tuser = cxp2sbu_tuser;
  assign sbu2nwp_tid   = cxp2sbu_tid;

  shell_watchdog u_watchdog (
    .mlx2sbu_clk (mlx2sbu_clk),
    .arst_n      (arst_n),
    .watchdog    (sbu2mlx_watchdog)
  );

endmodule

//--- rtl/shell_watchdog.sv
// shell watchdog toggle
`timescale 1ns/10ps

module shell_watchdog (
  input  logic mlx2sbu_clk,
  input  logic arst_n,
  output logic watchdog
);

  logic [fw_pkg::WATCHDOG_BITS-1:0] cnt;

  always_ff @(posedge mlx2sbu_clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1; // free running
    end
  end

  assign watchdog = cnt[fw_pkg::WATCHDOG_BITS-1];

endmodule

//--- rtl/verdict_merge.sv
// joins packet data with its verdict
`timescale 1ns/10ps

module verdict_merge (
  input  logic                       mlx2sbu_clk,
  input  logic                       arst_n,
  input  logic                       data_empty,
  input  logic [fw_pkg::TDATA_W-1:0] data_tdata,
  input  logic [fw_pkg::TKEEP_W-1:0] data_tkeep,
  input  logic                       data_tlast,
  input  logic                       tuple_empty,
  input  logic                       tuple_verdict,
  input  logic                       egress_rdy,
  output logic                       data_rd,
  output logic                       tuple_rd,
  output logic                       egress_vld,
  output logic [fw_pkg::TDATA_W-1:0] egress_tdata,
  output logic [fw_pkg::TKEEP_W-1:0] egress_tkeep,
  output logic                       egress_tlast,
  output logic [fw_pkg::TUSER_W-1:0] egress_tuser
);

  fw_pkg::pkt_pos_t pos;
  logic             first;

  assign first = (pos == fw_pkg::PKT_FIRST);

  always_ff @(posedge mlx2sbu_clk or negedge arst_n) begin
    if (!arst_n) begin
      pos <= fw_pkg::PKT_FIRST;
    end else if (data_rd) begin
      pos <= data_tlast ? fw_pkg::PKT_FIRST : fw_pkg::PKT_BODY;
    end
  end

  // first beat waits for its verdict
  assign egress_vld = !data_empty && (first ? !tuple_empty : 1'b1);
  assign data_rd    = egress_vld && egress_rdy;
  assign tuple_rd   = first && data_rd;

  assign egress_tdata = data_tdata;
  assign egress_tkeep = data_tkeep;
  assign egress_tlast = data_tlast;
  assign egress_tuser = first ? {{(fw_pkg::TUSER_W-1){1'b0}}, tuple_verdict} : '0;

endmodule

//--- rtl/flow_classifier.sv
// allow-list flow classifier
`timescale 1ns/10ps

module flow_classifier (
  input  logic                            mlx2sbu_clk,
  input  logic                            arst_n,
  input  logic                            beat_accept,
  input  logic [fw_pkg::TDATA_W-1:0]      beat_tdata,
  input  logic                            beat_tlast,
  input  logic                            cfg_wr,
  input  logic [fw_pkg::RULE_INDEX_W-1:0] cfg_index,
  input  logic [fw_pkg::IP_W-1:0]         cfg_dst_ip,
  input  logic                            cfg_enable,
  output logic                            verdict_wr,
  output logic                            verdict
);

  logic [fw_pkg::RULE_COUNT-1:0] rule_en;
  logic [fw_pkg::IP_W-1:0]       rule_ip [fw_pkg::RULE_COUNT];

  fw_pkg::pkt_pos_t pos;

  logic [fw_pkg::IP_W-1:0] pkt_ip;
  logic                    match_now;
  logic                    match_q;

  // rule table
  always_ff @(posedge mlx2sbu_clk or negedge arst_n) begin
    if (!arst_n) begin
      rule_en <= '0;
    end else if (cfg_wr) begin
      rule_en[cfg_index] <= cfg_enable;
    end
  end

  always_ff @(posedge mlx2sbu_clk) begin
    if (cfg_wr) begin
      rule_ip[cfg_index] <= cfg_dst_ip;
    end
  end

  // byte DST_IP_BYTE ends up as the address msb
  assign pkt_ip = beat_tdata[fw_pkg::DST_IP_BYTE*8+7 -: fw_pkg::IP_W];

  always_comb begin
    match_now = 1'b0;
    for (int i = 0; i < fw_pkg::RULE_COUNT; i++) begin
      if (rule_en[i] && (rule_ip[i] == pkt_ip)) begin
        match_now = 1'b1;
      end
    end
  end

  always_ff @(posedge mlx2sbu_clk or negedge arst_n) begin
    if (!arst_n) begin
      pos     <= fw_pkg::PKT_FIRST;
      match_q <= 1'b0;
    end else if (beat_accept) begin
      if (pos == fw_pkg::PKT_FIRST) begin
        match_q <= match_now; // held for the rest of the packet
      end
      if (beat_tlast) begin
        pos <= fw_pkg::PKT_FIRST;
      end else begin
        pos <= fw_pkg::PKT_BODY;
      end
    end
  end

  // single-beat packets use the live match
  assign verdict_wr = beat_accept && beat_tlast;
  assign verdict    = (pos == fw_pkg::PKT_FIRST) ? match_now : match_q;

endmodule

//--- rtl/sync_fifo.sv
// show-ahead synchronous fifo
`timescale 1ns/10ps

module sync_fifo #(
  parameter int WIDTH      = 1,
  parameter int DEPTH_LOG2 = 6
) (
  input  logic             mlx2sbu_clk,
  input  logic             arst_n,
  input  logic             wr_en,
  input  logic [WIDTH-1:0] din,
  input  logic             rd_en,
  output logic [WIDTH-1:0] dout,
  output logic             full,
  output logic             empty
);

  logic [WIDTH-1:0] mem [2**DEPTH_LOG2];

  // extra msb tells full from empty
  logic [DEPTH_LOG2:0] wr_ptr;
  logic [DEPTH_LOG2:0] rd_ptr;

  logic do_wr;
  logic do_rd;

  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) &&
                 (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]);

  always_ff @(posedge mlx2sbu_clk) begin
    if (do_wr) begin
      mem[wr_ptr[DEPTH_LOG2-1:0]] <= din;
    end
  end

  always_ff @(posedge mlx2sbu_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  assign dout = mem[rd_ptr[DEPTH_LOG2-1:0]]; // head visible while not empty

endmodule

//--- rtl/fw_pkg.sv
// firewall shell shared definitions
package fw_pkg;

  // stream widths
  localparam int TDATA_W = 256;
  localparam int TKEEP_W = 32;
  localparam int TUSER_W = 12;
  localparam int TID_W   = 3;

  localparam int FIFO_DEPTH_LOG2 = 6; // 64 entries hold the longest packet

  // allow list
  localparam int RULE_COUNT   = 4;
  localparam int RULE_INDEX_W = 2;
  localparam int IP_W         = 32;

  // msb byte of ipv4 dst addr in first beat (14 eth + 16 ip)
  localparam int DST_IP_BYTE = 30;

  localparam int WATCHDOG_BITS = 5; // toggles every 16 cycles

  // identity outputs
  localparam logic [23:0] VENDOR_ID       = 24'h0002c9;
  localparam logic [15:0] PRODUCT_ID      = 16'd4;
  localparam logic [15:0] PRODUCT_VERSION = 16'd1;
  localparam logic [31:0] CAPS            = 32'd2;
  localparam logic [15:0] CAPS_LEN        = 16'd0;
  localparam logic [23:0] CAPS_ADDR       = 24'd0;

  // position of the next beat within a packet
  typedef enum logic {
    PKT_FIRST,
    PKT_BODY
  } pkt_pos_t;

endpackage
